//--- hdl/dma_pkg.sv
`default_nettype none

package dma_pkg;

    // byte address into the word memory
    localparam int ADDR_BITS = 10;

    // transfer length in bytes, one extra bit so a full 1024 byte run fits
    localparam int LEN_BITS = 11;

    // memory word and fifo byte widths
    localparam int WORD_BITS = 16;
    localparam int BYTE_BITS = 8;

    // word memory size and its word index width
    localparam int MEM_WORDS = 512;
    localparam int WORD_INDEX_BITS = $clog2(MEM_WORDS);

    // byte fifo, depth must stay a power of two
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_BITS = 4;

endpackage

`default_nettype wire

//--- hdl/word_memory.sv
`timescale 1ns/100ps
`default_nettype none

module word_memory
    import dma_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    // preload port, word indexed
    input  wire logic                       load_write,
    input  wire logic [WORD_INDEX_BITS-1:0] load_address,
    input  wire logic [WORD_BITS-1:0]       load_data,
    // dma read port
    input  wire logic                       mem_request,
    input  wire logic [ADDR_BITS-1:0]       mem_address,
    output logic                            mem_ack,
    output logic [WORD_BITS-1:0]            mem_rdata
);

    logic [WORD_BITS-1:0] words [MEM_WORDS];
    logic [WORD_INDEX_BITS-1:0] word_index;
    logic pending;

    // byte address to word index, bit 0 is always clear on this bus
    assign word_index = mem_address[ADDR_BITS-1:1];

    // preload writes
    always_ff @(posedge clk) begin
        if (load_write) begin
            words[load_address] <= load_data;
        end
    end

    // read data lands together with the ack
    always_ff @(posedge clk) begin
        if (mem_request && !pending) begin
            mem_rdata <= words[word_index];
        end
    end

    // one ack per request
    // pending stays set while the request is still held after the ack
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_ack <= 1'b0;
            pending <= 1'b0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_request && !pending) begin
                mem_ack <= 1'b1;
                pending <= 1'b1;
            end else if (!mem_request) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/memory_dma.sv
`timescale 1ns/100ps
`default_nettype none

module memory_dma
    import dma_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    // control and status
    input  wire logic                 start,
    input  wire logic                 stop,
    input  wire logic                 byte_swap,
    input  wire logic [ADDR_BITS-1:0] starting_address,
    input  wire logic [LEN_BITS-1:0]  transfer_length,
    output logic                      busy,
    // memory bus
    output logic                      mem_request,
    output logic [ADDR_BITS-1:0]      mem_address,
    output logic [1:0]                mem_wmask,
    input  wire logic                 mem_ack,
    input  wire logic [WORD_BITS-1:0] mem_rdata,
    // fifo write side
    output logic                      fifo_write,
    output logic [BYTE_BITS-1:0]      fifo_wdata,
    input  wire logic                 fifo_full
);

    // start/stop stage
    logic dma_start;
    logic dma_stop;
    logic [ADDR_BITS-1:0] start_address_q;
    logic [LEN_BITS-1:0] length_q;
    logic swap_q;

    // stop wins over start, stop level holds until the next start
    always_ff @(posedge clk) begin
        if (reset) begin
            dma_start <= 1'b0;
            dma_stop <= 1'b0;
        end else begin
            dma_start <= start && !stop;
            if (stop) begin
                dma_stop <= 1'b1;
            end else if (start) begin
                dma_stop <= 1'b0;
            end
        end
    end

    // transfer settings, captured on the strobe
    always_ff @(posedge clk) begin
        if (start && !stop) begin
            start_address_q <= starting_address;
            length_q <= transfer_length;
            swap_q <= byte_swap;
        end
    end

    // memory bus controller
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,
        MEM_TRANSFER
    } mem_state_t;

    mem_state_t mem_state;
    mem_state_t mem_state_next;

    logic [LEN_BITS-1:0] remaining;
    logic last_word;
    logic almost_last;
    logic unaligned_start;
    logic unaligned_end;

    // returned word handed to the fifo side
    logic rdata_ready;
    logic rdata_ack;
    logic rdata_end;
    logic [1:0] rdata_valid;
    logic [WORD_BITS-1:0] rdata_buffer;

    // remaining counts bytes not yet requested
    assign last_word = (remaining == '0);
    assign almost_last = (remaining <= LEN_BITS'(2));

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_state <= MEM_IDLE;
        end else begin
            mem_state <= mem_state_next;
        end
    end

    always_comb begin
        mem_state_next = mem_state;
        case (mem_state)
            MEM_IDLE: begin
                if (dma_start) begin
                    mem_state_next = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (dma_stop || last_word) begin
                    mem_state_next = MEM_IDLE;
                end else if (rdata_ready) begin
                    mem_state_next = MEM_TRANSFER;
                end
            end
            MEM_TRANSFER: begin
                // request is held, so stop only lands on the ack
                if (mem_ack) begin
                    if (dma_stop || last_word) begin
                        mem_state_next = MEM_IDLE;
                    end else begin
                        mem_state_next = MEM_WAIT;
                    end
                end
            end
            default: begin
                mem_state_next = MEM_IDLE;
            end
        endcase
    end

    // request, address and word handoff flags
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_request <= 1'b0;
            mem_address <= '0;
            rdata_ack <= 1'b0;
            rdata_end <= 1'b1;
        end else begin
            rdata_ack <= 1'b0;
            case (mem_state)
                MEM_IDLE: begin
                    mem_request <= 1'b0;
                    rdata_end <= 1'b1;
                    if (dma_start) begin
                        mem_address <= {start_address_q[ADDR_BITS-1:1], 1'b0};
                        rdata_end <= 1'b0;
                    end
                end
                MEM_WAIT: begin
                    if (mem_state_next == MEM_TRANSFER) begin
                        mem_request <= 1'b1;
                    end
                end
                MEM_TRANSFER: begin
                    // drop request for at least one cycle after the ack
                    if (mem_ack) begin
                        mem_request <= 1'b0;
                        mem_address <= mem_address + ADDR_BITS'(2);
                        rdata_ack <= 1'b1;
                        rdata_end <= last_word;
                    end
                end
                default: begin
                    mem_request <= 1'b0;
                end
            endcase
        end
    end

    // byte count, masks and returned data
    always_ff @(posedge clk) begin
        case (mem_state)
            MEM_IDLE: begin
                if (dma_start) begin
                    remaining <= length_q;
                    unaligned_start <= start_address_q[0];
                    // odd end when start and length parities differ
                    unaligned_end <= start_address_q[0] ^ length_q[0];
                end
            end
            MEM_WAIT: begin
                if (mem_state_next == MEM_TRANSFER) begin
                    unaligned_start <= 1'b0;
                    if (unaligned_start) begin
                        // odd start, low byte only
                        mem_wmask <= 2'b01;
                        remaining <= remaining - LEN_BITS'(1);
                    end else if (unaligned_end && almost_last) begin
                        // odd end, high byte only
                        mem_wmask <= 2'b10;
                        remaining <= remaining - LEN_BITS'(1);
                    end else begin
                        mem_wmask <= 2'b11;
                        remaining <= remaining - LEN_BITS'(2);
                    end
                end
            end
            MEM_TRANSFER: begin
                if (mem_ack) begin
                    rdata_valid <= mem_wmask;
                    rdata_buffer <= mem_rdata;
                end
            end
            default: begin
            end
        endcase
    end

    // fifo-side controller
    typedef enum logic [1:0] {
        FIFO_IDLE,
        FIFO_WAIT,
        FIFO_BYTE_1,
        FIFO_BYTE_2
    } fifo_state_t;

    fifo_state_t fifo_state;
    fifo_state_t fifo_state_next;

    logic split_shift;
    logic split_waiting;
    logic byte_done;
    logic [1:0] split_valid;
    logic [WORD_BITS-1:0] split_buffer;

    always_ff @(posedge clk) begin
        if (reset || dma_stop) begin
            fifo_state <= FIFO_IDLE;
        end else begin
            fifo_state <= fifo_state_next;
        end
    end

    // emit high half first, skip a byte with its mask bit clear
    always_comb begin
        fifo_state_next = fifo_state;
        split_shift = 1'b0;
        fifo_write = 1'b0;
        byte_done = 1'b0;
        fifo_wdata = split_buffer[WORD_BITS-1 -: BYTE_BITS];
        case (fifo_state)
            FIFO_IDLE: begin
                if (dma_start) begin
                    fifo_state_next = FIFO_WAIT;
                end
            end
            FIFO_WAIT: begin
                if (rdata_ack || split_waiting) begin
                    fifo_state_next = FIFO_BYTE_1;
                end else if (rdata_end) begin
                    fifo_state_next = FIFO_IDLE;
                end
            end
            FIFO_BYTE_1: begin
                fifo_write = !fifo_full && split_valid[1];
                byte_done = fifo_write || !split_valid[1];
                if (byte_done) begin
                    fifo_state_next = FIFO_BYTE_2;
                    split_shift = 1'b1;
                end
            end
            FIFO_BYTE_2: begin
                fifo_write = !fifo_full && split_valid[1];
                byte_done = fifo_write || !split_valid[1];
                if (byte_done) begin
                    split_shift = 1'b1;
                    fifo_state_next = FIFO_WAIT;
                    // last word out and nothing parked behind it
                    if (!rdata_ack && !split_waiting && rdata_end) begin
                        fifo_state_next = FIFO_IDLE;
                    end
                end
            end
            default: begin
                fifo_state_next = FIFO_IDLE;
            end
        endcase
    end

    // ready asks the memory side for another word
    // waiting marks a word parked in rdata_buffer
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_ready <= 1'b0;
            split_waiting <= 1'b0;
        end else begin
            case (fifo_state)
                FIFO_IDLE: begin
                    rdata_ready <= dma_start;
                    split_waiting <= 1'b0;
                end
                FIFO_WAIT: begin
                    if (rdata_ack || split_waiting) begin
                        rdata_ready <= 1'b0;
                        split_waiting <= 1'b0;
                    end
                end
                FIFO_BYTE_1: begin
                    if (rdata_ack) begin
                        split_waiting <= 1'b1;
                    end
                end
                FIFO_BYTE_2: begin
                    if (rdata_ack) begin
                        split_waiting <= 1'b1;
                    end
                    if (byte_done) begin
                        rdata_ready <= !rdata_end;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // split buffer, halves swapped on load when requested
    always_ff @(posedge clk) begin
        if ((fifo_state == FIFO_WAIT) && (rdata_ack || split_waiting)) begin
            split_valid <= rdata_valid;
            if (swap_q) begin
                split_buffer <= {rdata_buffer[BYTE_BITS-1:0],
                                 rdata_buffer[WORD_BITS-1:BYTE_BITS]};
            end else begin
                split_buffer <= rdata_buffer;
            end
        end else if (split_shift) begin
            split_valid <= {split_valid[0], 1'b0};
            split_buffer <= {split_buffer[BYTE_BITS-1:0], {BYTE_BITS{1'b0}}};
        end
    end

    // busy, high from the cycle after start until both sides are idle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= (start && !stop) ||
                    dma_start ||
                    (mem_state != MEM_IDLE) ||
                    (fifo_state != FIFO_IDLE);
        end
    end

endmodule

`default_nettype wire

//--- hdl/byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module byte_fifo
    import dma_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    // write side
    input  wire logic                 fifo_write,
    input  wire logic [BYTE_BITS-1:0] fifo_wdata,
    output logic                      fifo_full,
    // read side, head byte shown while not empty
    input  wire logic                 fifo_read,
    output logic [BYTE_BITS-1:0]      fifo_rdata,
    output logic                      fifo_empty
);

    logic [BYTE_BITS-1:0] buffer [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] write_ptr;
    logic [FIFO_PTR_BITS-1:0] read_ptr;
    logic [FIFO_PTR_BITS:0] count;
    logic do_write;
    logic do_read;

    // writes when full and reads when empty are dropped
    assign do_write = fifo_write && !fifo_full;
    assign do_read = fifo_read && !fifo_empty;

    assign fifo_full = (count == (FIFO_PTR_BITS + 1)'(FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign fifo_rdata = buffer[read_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            buffer[write_ptr] <= fifo_wdata;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (do_read) begin
                read_ptr <= read_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dma_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module dma_subsystem
    import dma_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    // memory preload
    input  wire logic                       load_write,
    input  wire logic [WORD_INDEX_BITS-1:0] load_address,
    input  wire logic [WORD_BITS-1:0]       load_data,
    // dma control
    input  wire logic                       start,
    input  wire logic                       stop,
    input  wire logic                       byte_swap,
    input  wire logic [ADDR_BITS-1:0]       starting_address,
    input  wire logic [LEN_BITS-1:0]        transfer_length,
    output logic                            busy,
    // fifo read side
    input  wire logic                       fifo_read,
    output logic [BYTE_BITS-1:0]            fifo_rdata,
    output logic                            fifo_empty
);

    // memory bus
    logic mem_request;
    logic [ADDR_BITS-1:0] mem_address;
    logic mem_ack;
    logic [WORD_BITS-1:0] mem_rdata;

    // fifo write side
    logic fifo_write;
    logic [BYTE_BITS-1:0] fifo_wdata;
    logic fifo_full;

    word_memory i_memory (
        .clk          (clk),
        .reset        (reset),
        .load_write   (load_write),
        .load_address (load_address),
        .load_data    (load_data),
        .mem_request  (mem_request),
        .mem_address  (mem_address),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata)
    );

    // read-only memory, so the byte mask stays inside the dma
    memory_dma i_dma (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .stop             (stop),
        .byte_swap        (byte_swap),
        .starting_address (starting_address),
        .transfer_length  (transfer_length),
        .busy             (busy),
        .mem_request      (mem_request),
        .mem_address      (mem_address),
        .mem_wmask        (),
        .mem_ack          (mem_ack),
        .mem_rdata        (mem_rdata),
        .fifo_write       (fifo_write),
        .fifo_wdata       (fifo_wdata),
        .fifo_full        (fifo_full)
    );

    byte_fifo i_fifo (
        .clk        (clk),
        .reset      (reset),
        .fifo_write (fifo_write),
        .fifo_wdata (fifo_wdata),
        .fifo_full  (fifo_full),
        .fifo_read  (fifo_read),
        .fifo_rdata (fifo_rdata),
        .fifo_empty (fifo_empty)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 20 ns period, starts low
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verif/dma_props.sv
`timescale 1ns/100ps
`default_nettype none

module dma_props
    import dma_pkg::*;
(
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 mem_request,
    input wire logic                 mem_ack,
    input wire logic [ADDR_BITS-1:0] mem_address,
    input wire logic                 fifo_write,
    input wire logic                 fifo_full
);

    // request held until the memory answers
    assert property (@(posedge clk) disable iff (reset)
        (mem_request && !mem_ack) |=> mem_request)
        else $error("mem_request dropped before mem_ack");

    // no write into a full fifo
    assert property (@(posedge clk) disable iff (reset)
        !(fifo_write && fifo_full))
        else $error("fifo_write asserted while fifo_full");

    // word aligned bus address
    assert property (@(posedge clk) disable iff (reset)
        mem_address[0] == 1'b0)
        else $error("mem_address is odd");

endmodule

`default_nettype wire

//--- verif/dma_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dma_tb
    import dma_pkg::*;
();

    localparam int SEED = 55608;
    localparam int RANDOM_TESTS = 20;
    localparam int MAX_RANDOM_LENGTH = 64;
    // aligned, odd ends, swap, back-pressure, stop plus the one after it
    localparam int FIXED_LENGTH = 64 + 30 + 65 + 100 + 216;
    localparam int TIMEOUT_CYCLES =
        (FIXED_LENGTH + RANDOM_TESTS * MAX_RANDOM_LENGTH) * 8 + 2000;

    logic clk;
    logic reset;
    logic load_write;
    logic [WORD_INDEX_BITS-1:0] load_address;
    logic [WORD_BITS-1:0] load_data;
    logic start;
    logic stop;
    logic byte_swap;
    logic [ADDR_BITS-1:0] starting_address;
    logic [LEN_BITS-1:0] transfer_length;
    logic busy;
    logic fifo_read = 1'b0;
    logic [BYTE_BITS-1:0] fifo_rdata;
    logic fifo_empty;

    // one byte per memory byte address
    logic [BYTE_BITS-1:0] shadow [1 << ADDR_BITS];
    int expected[$];
    int received[$];
    int received_count = 0;
    int count_base;
    int cycle_count = 0;
    int actual_byte;
    logic drain_enable;
    string test_name;

    tb_clock i_clock (
        .clk (clk)
    );

    dma_subsystem i_dut (
        .clk              (clk),
        .reset            (reset),
        .load_write       (load_write),
        .load_address     (load_address),
        .load_data        (load_data),
        .start            (start),
        .stop             (stop),
        .byte_swap        (byte_swap),
        .starting_address (starting_address),
        .transfer_length  (transfer_length),
        .busy             (busy),
        .fifo_read        (fifo_read),
        .fifo_rdata       (fifo_rdata),
        .fifo_empty       (fifo_empty)
    );

    bind memory_dma dma_props i_props (
        .clk         (clk),
        .reset       (reset),
        .mem_request (mem_request),
        .mem_ack     (mem_ack),
        .mem_address (mem_address),
        .fifo_write  (fifo_write),
        .fifo_full   (fifo_full)
    );

    // byte pattern where every address bit matters and neighbours differ
    function automatic logic [BYTE_BITS-1:0] fill_byte(input logic [ADDR_BITS-1:0] address);
        return address[7:0] ^ {4{address[ADDR_BITS-1:8]}} ^ 8'h5a;
    endfunction

    // expected byte at a transfer address
    // swap picks the other byte of the same word
    function automatic logic [BYTE_BITS-1:0] expected_byte(input int address, input logic swap);
        logic [ADDR_BITS-1:0] index;
        index = ADDR_BITS'(address);
        index[0] = index[0] ^ swap;
        return shadow[index];
    endfunction

    task automatic check(input string name, input int wanted, input int actual);
        if (wanted != actual) begin
            $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, wanted, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    // even byte in bits 15:8, odd byte in 7:0
    task automatic preload_memory();
        for (int w = 0; w < MEM_WORDS; w++) begin
            @(posedge clk);
            #2;
            load_write = 1'b1;
            load_address = WORD_INDEX_BITS'(w);
            load_data = {shadow[ADDR_BITS'(2 * w)], shadow[ADDR_BITS'(2 * w + 1)]};
        end
        @(posedge clk);
        #2;
        load_write = 1'b0;
    endtask

    // queue the reference bytes, then strobe start for one cycle
    task automatic start_transfer(input string name, input int addr, input int len,
                                  input logic swap);
        test_name = name;
        count_base = received_count;
        for (int a = addr; a < addr + len; a++) begin
            expected.push_back(int'(expected_byte(a, swap)));
        end
        @(posedge clk);
        #2;
        start = 1'b1;
        byte_swap = swap;
        starting_address = ADDR_BITS'(addr);
        transfer_length = LEN_BITS'(len);
        @(posedge clk);
        #2;
        start = 1'b0;
        @(negedge clk);
        check({name, " busy"}, 1, int'(busy));
    endtask

    // busy low, fifo drained and every byte compared
    task automatic wait_idle();
        while (busy) begin
            @(negedge clk);
        end
        while (!fifo_empty || received.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_transfer(input string name, input int addr, input int len,
                                input logic swap);
        start_transfer(name, addr, len, swap);
        wait_idle();
        check({name, " byte count"}, len, received_count - count_base);
    endtask

    // random reads in about three cycles of four
    always @(posedge clk) begin
        #2;
        fifo_read = drain_enable && (($urandom % 4) != 0);
    end

    // head byte taken by the fifo at the next edge
    always @(negedge clk) begin
        if (fifo_read && !fifo_empty) begin
            received.push_back(int'(fifo_rdata));
        end
    end

    // in order against the reference stream
    always @(posedge clk) begin
        if (received.size() != 0) begin
            actual_byte = received.pop_front();
            received_count++;
            if (expected.size() == 0) begin
                abort_run($sformatf("%s: byte 0x%0h arrived with none expected",
                                    test_name, actual_byte));
            end else begin
                check(test_name, expected.pop_front(), actual_byte);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, run still going after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        int addr;
        int len;
        int fall_cycles;
        logic swap;
        void'($urandom(SEED));
        reset = 1'b1;
        load_write = 1'b0;
        load_address = '0;
        load_data = '0;
        start = 1'b0;
        stop = 1'b0;
        byte_swap = 1'b0;
        starting_address = '0;
        transfer_length = '0;
        drain_enable = 1'b1;
        for (int a = 0; a < (1 << ADDR_BITS); a++) begin
            shadow[ADDR_BITS'(a)] = fill_byte(ADDR_BITS'(a));
        end
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        preload_memory();

        run_transfer("aligned", 2, 64, 1'b0);
        // no late byte once the engine has gone idle
        repeat (4) @(negedge clk);
        check("aligned fifo empty", 1, int'(fifo_empty));
        // partial first word, partial last word, both
        run_transfer("odd start", 3, 7, 1'b0);
        run_transfer("odd end", 10, 9, 1'b0);
        run_transfer("odd both", 21, 10, 1'b0);
        run_transfer("two bytes", 5, 2, 1'b0);
        run_transfer("single odd", 101, 1, 1'b0);
        run_transfer("single even", 200, 1, 1'b0);
        run_transfer("swap aligned", 64, 32, 1'b1);
        run_transfer("swap unaligned", 131, 33, 1'b1);

        // reads held off until the fifo fills and stays full
        drain_enable = 1'b0;
        start_transfer("backpressure", 400, 100, 1'b0);
        while (!i_dut.fifo_full) begin
            @(negedge clk);
        end
        repeat (100) @(negedge clk);
        check("backpressure still full", 1, int'(i_dut.fifo_full));
        check("backpressure busy", 1, int'(busy));
        drain_enable = 1'b1;
        wait_idle();
        check("backpressure byte count", 100, received_count - count_base);

        // stop part way through and expect busy to drop within 4 cycles
        start_transfer("stop", 300, 200, 1'b0);
        repeat (40) @(negedge clk);
        @(posedge clk);
        #2;
        stop = 1'b1;
        @(posedge clk);
        #2;
        stop = 1'b0;
        fall_cycles = 1;
        @(negedge clk);
        while (busy && fall_cycles < 4) begin
            @(negedge clk);
            fall_cycles++;
        end
        check("stop busy fall", 0, int'(busy));
        wait_idle();
        // a stopped run delivers only part of the stream
        check("stop prefix length", 1, int'((received_count - count_base) < 200));
        // rest of the stream never comes
        expected.delete();
        run_transfer("after stop", 7, 16, 1'b0);

        for (int i = 0; i < RANDOM_TESTS; i++) begin
            len = 1 + int'($urandom % MAX_RANDOM_LENGTH);
            addr = int'($urandom % ((1 << ADDR_BITS) + 1 - len));
            swap = ($urandom % 2) == 1;
            run_transfer($sformatf("random %0d", i), addr, len, swap);
        end

        @(negedge clk);
        check("final fifo empty", 1, int'(fifo_empty));
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/dma_pkg.sv
hdl/word_memory.sv
hdl/memory_dma.sv
hdl/byte_fifo.sv
hdl/dma_subsystem.sv
verif/tb_clock.sv
verif/dma_props.sv
verif/dma_tb.sv

//--- run.sh
#!/bin/sh
# build the dma testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dma_tb -f compile.f -o dma_sim &&
    ./obj_dir/dma_sim | tee /dev/stderr | grep -q "Simulation passed" ||
    exit 1
